/* include/slave_defs.svh */
`ifndef SLAVE_DEFS_SVH
`define SLAVE_DEFS_SVH

// memory word and address sizes
`define SLAVE_DATA_WIDTH 32
`define SLAVE_ADDR_WIDTH 8
`define SLAVE_MEM_DEPTH 256

// bits of the slave id field in the frame
`define SLAVE_ID_WIDTH 2

// extra cycles a single read waits before its first word
`define SLAVE_READ_DELAY 3

// configuration frame
`define SLAVE_START_CODE 3'b111
`define SLAVE_FRAME_BITS 15

`endif

/* verilog/bus_frame_pkg.sv */
`include "slave_defs.svh"

package bus_frame_pkg;

    // read/write bit of the frame
    typedef enum logic {
        xfer_read  = 1'b0,
        xfer_write = 1'b1
    } xfer_dir_t;

    // frame fields in wire order, msb is sent first
    typedef struct packed {
        logic [2:0]                    start_code;
        logic [`SLAVE_ID_WIDTH-1:0]    id;
        xfer_dir_t                     dir;
        logic                          burst;
        logic [`SLAVE_ADDR_WIDTH-1:0]  address;
    } frame_fields_t;

    // shifted in through raw, decoded through fields
    typedef union packed {
        frame_fields_t                 fields;
        logic [`SLAVE_FRAME_BITS-1:0]  raw;
    } frame_word_t;

endpackage

/* verilog/slave_state_pkg.sv */
package slave_state_pkg;

    // transfer controller states
    typedef enum logic [2:0] {
        idle,
        write_bits,
        write_store,
        read_wait,
        read_bits,
        read_fetch
    } ctrl_state_t;

endpackage

/* verilog/slave_ifs.sv */
`timescale 1ns/1ps
`include "slave_defs.svh"

// accepted frame, from receiver to controller
interface frame_if;
    logic                          accept;
    bus_frame_pkg::xfer_dir_t      dir;
    logic                          burst;
    logic [`SLAVE_ADDR_WIDTH-1:0]  address;
    // controller not idle, receiver stops listening
    logic                          busy;

    modport receiver (
        output accept,
        output dir,
        output burst,
        output address,
        input  busy
    );

    modport controller (
        input  accept,
        input  dir,
        input  burst,
        input  address,
        output busy
    );
endinterface

// controller side of the serial shift register
interface word_if;
    logic                          load;
    logic [`SLAVE_DATA_WIDTH-1:0]  load_word;
    logic                          shift;
    logic [`SLAVE_DATA_WIDTH-1:0]  word;
    logic                          word_done;

    modport controller (
        output load,
        output load_word,
        output shift,
        input  word,
        input  word_done
    );

    modport shifter (
        input  load,
        input  load_word,
        input  shift,
        output word,
        output word_done
    );
endinterface

/* verilog/frame_receiver.sv */
`timescale 1ns/1ps
`include "slave_defs.svh"

module frame_receiver #(
    parameter int unsigned slave_id = 1
) (
    input  logic      clk,
    input  logic      rstN,
    input  logic      control,
    frame_if.receiver frame
);

    localparam int cnt_w = $clog2(`SLAVE_FRAME_BITS);

    bus_frame_pkg::frame_word_t  shift_reg;
    logic [cnt_w-1:0]            bit_cnt;
    logic                        receiving;
    logic                        frame_done;
    logic                        start_bit;
    logic                        code_ok;
    logic                        id_ok;

    // first 1 on control while idle is the first start bit
    assign start_bit = control && !receiving && !frame_done && !frame.busy;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            receiving  <= 1'b0;
            frame_done <= 1'b0;
            bit_cnt    <= '0;
        end else begin
            frame_done <= 1'b0;
            if (receiving) begin
                bit_cnt <= bit_cnt + 1'b1;
                // this edge takes the last frame bit
                if (bit_cnt == cnt_w'(`SLAVE_FRAME_BITS - 1)) begin
                    receiving  <= 1'b0;
                    frame_done <= 1'b1;
                end
            end else if (start_bit) begin
                receiving <= 1'b1;
                bit_cnt   <= cnt_w'(1);
            end
        end
    end

    // msb first, so each bit enters at the bottom
    always_ff @(posedge clk) begin
        if (receiving || start_bit) begin
            shift_reg.raw <= {shift_reg.raw[`SLAVE_FRAME_BITS-2:0], control};
        end
    end

    assign code_ok = shift_reg.fields.start_code == `SLAVE_START_CODE;
    assign id_ok   = shift_reg.fields.id == `SLAVE_ID_WIDTH'(slave_id);

    // frames for other slaves are dropped here
    assign frame.accept  = frame_done && code_ok && id_ok;
    assign frame.dir     = shift_reg.fields.dir;
    assign frame.burst   = shift_reg.fields.burst;
    assign frame.address = shift_reg.fields.address;

endmodule

/* verilog/word_shifter.sv */
`timescale 1ns/1ps
`include "slave_defs.svh"

module word_shifter (
    input  logic     clk,
    input  logic     rstN,
    input  logic     wD,
    output logic     rD,
    word_if.shifter  word
);

    localparam int dw    = `SLAVE_DATA_WIDTH;
    localparam int cnt_w = $clog2(dw) + 1;

    logic [dw-1:0]     shift_reg;
    logic [cnt_w-1:0]  bit_cnt;
    logic              done_now;

    // counter sits at dw for one cycle after the last shift
    assign done_now = bit_cnt == cnt_w'(dw);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shift_reg <= '0;
            bit_cnt   <= '0;
        end else if (word.load) begin
            shift_reg <= word.load_word;
            bit_cnt   <= '0;
        end else begin
            if (word.shift) begin
                shift_reg <= {shift_reg[dw-2:0], wD};
            end
            if (done_now) begin
                // a shift here is already the next word's first bit
                bit_cnt <= word.shift ? cnt_w'(1) : '0;
            end else if (word.shift) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    assign word.word      = shift_reg;
    assign word.word_done = done_now;

    // read data leaves from the top, msb first
    assign rD = shift_reg[dw-1];

endmodule

/* verilog/slave_memory.sv */
`timescale 1ns/1ps
`include "slave_defs.svh"

module slave_memory (
    input  logic                          clk,
    input  logic                          we,
    input  logic [`SLAVE_ADDR_WIDTH-1:0]  waddr,
    input  logic [`SLAVE_ADDR_WIDTH-1:0]  raddr,
    input  logic [`SLAVE_DATA_WIDTH-1:0]  wdata,
    output logic [`SLAVE_DATA_WIDTH-1:0]  rdata
);

    logic [`SLAVE_DATA_WIDTH-1:0] mem [0:`SLAVE_MEM_DEPTH-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* verilog/transfer_ctrl.sv */
`timescale 1ns/1ps
`include "slave_defs.svh"

module transfer_ctrl (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          valid,
    input  logic                          last,
    output logic                          ready,
    frame_if.controller                   frame,
    word_if.controller                    word,
    output logic                          mem_we,
    output logic [`SLAVE_ADDR_WIDTH-1:0]  mem_waddr,
    output logic [`SLAVE_ADDR_WIDTH-1:0]  mem_raddr,
    output logic [`SLAVE_DATA_WIDTH-1:0]  mem_wdata,
    input  logic [`SLAVE_DATA_WIDTH-1:0]  mem_rdata
);

    // also covers the two fetch cycles of a burst read
    localparam int delay_cnt_w = $clog2(`SLAVE_READ_DELAY + 2);

    slave_state_pkg::ctrl_state_t  state;
    logic                          burst_q;
    logic                          last_q;
    logic [`SLAVE_ADDR_WIDTH-1:0]  addr_q;
    logic [delay_cnt_w-1:0]        delay_cnt;
    logic                          fetch_now;
    logic                          burst_more;
    logic                          bits_state;

    assign bits_state = (state == slave_state_pkg::write_bits) ||
                        (state == slave_state_pkg::read_bits);

    // last seen with the word's final bit ends the burst
    assign burst_more = burst_q && !last_q;

    // memory data is valid in these cycles
    assign fetch_now =
        ((state == slave_state_pkg::read_wait) &&
         (delay_cnt == delay_cnt_w'(`SLAVE_READ_DELAY))) ||
        ((state == slave_state_pkg::read_fetch) && (delay_cnt == delay_cnt_w'(1)));

    always_comb begin
        case (state)
            slave_state_pkg::write_store: ready = 1'b0;
            slave_state_pkg::read_wait:   ready = 1'b0;
            slave_state_pkg::read_fetch:  ready = 1'b0;
            // rD no longer holds data once the word is out
            slave_state_pkg::read_bits:   ready = !word.word_done;
            default:                      ready = 1'b1;
        endcase
    end

    assign word.shift     = valid && ready && bits_state;
    // a new frame also restarts the bit counter
    assign word.load      = fetch_now || ((state == slave_state_pkg::idle) && frame.accept);
    assign word.load_word = mem_rdata;

    // write lands as soon as the word is complete
    assign mem_we    = (state == slave_state_pkg::write_bits) && word.word_done;
    assign mem_waddr = addr_q;
    assign mem_wdata = word.word;
    // start the read on the accept edge so delay 0 also works
    assign mem_raddr = (state == slave_state_pkg::idle) ? frame.address : addr_q;

    assign frame.busy = state != slave_state_pkg::idle;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= slave_state_pkg::idle;
            burst_q   <= 1'b0;
            last_q    <= 1'b0;
            addr_q    <= '0;
            delay_cnt <= '0;
        end else begin
            // the final bit of each word leaves its last value here
            if (word.shift && !word.word_done) begin
                last_q <= last;
            end

            case (state)
                slave_state_pkg::idle: begin
                    if (frame.accept) begin
                        burst_q   <= frame.burst;
                        addr_q    <= frame.address;
                        delay_cnt <= '0;
                        if (frame.dir == bus_frame_pkg::xfer_write) begin
                            state <= slave_state_pkg::write_bits;
                        end else begin
                            state <= slave_state_pkg::read_wait;
                        end
                    end
                end
                slave_state_pkg::write_bits: begin
                    if (word.word_done) begin
                        state <= slave_state_pkg::write_store;
                    end
                end
                slave_state_pkg::write_store: begin
                    if (burst_more) begin
                        addr_q <= addr_q + 1'b1;
                        state  <= slave_state_pkg::write_bits;
                    end else begin
                        state <= slave_state_pkg::idle;
                    end
                end
                slave_state_pkg::read_wait: begin
                    delay_cnt <= delay_cnt + 1'b1;
                    if (fetch_now) begin
                        state <= slave_state_pkg::read_bits;
                    end
                end
                slave_state_pkg::read_bits: begin
                    if (word.word_done) begin
                        if (burst_more) begin
                            addr_q    <= addr_q + 1'b1;
                            delay_cnt <= '0;
                            state     <= slave_state_pkg::read_fetch;
                        end else begin
                            state <= slave_state_pkg::idle;
                        end
                    end
                end
                slave_state_pkg::read_fetch: begin
                    // one cycle for the new address, one for the data
                    delay_cnt <= delay_cnt + 1'b1;
                    if (fetch_now) begin
                        state <= slave_state_pkg::read_bits;
                    end
                end
                default: state <= slave_state_pkg::idle;
            endcase
        end
    end

endmodule

/* verilog/bus_slave.sv */
`timescale 1ns/1ps
`include "slave_defs.svh"

module bus_slave #(
    // each slave on the shared bus gets its own id
    parameter int unsigned slave_id = 1
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic ready
);

    logic                          mem_we;
    logic [`SLAVE_ADDR_WIDTH-1:0]  mem_waddr;
    logic [`SLAVE_ADDR_WIDTH-1:0]  mem_raddr;
    logic [`SLAVE_DATA_WIDTH-1:0]  mem_wdata;
    logic [`SLAVE_DATA_WIDTH-1:0]  mem_rdata;

    frame_if frame_bus ();
    word_if  word_bus ();

    frame_receiver #(
        .slave_id (slave_id)
    ) u_frame_receiver (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .frame   (frame_bus.receiver)
    );

    word_shifter u_word_shifter (
        .clk  (clk),
        .rstN (rstN),
        .wD   (wD),
        .rD   (rD),
        .word (word_bus.shifter)
    );

    transfer_ctrl u_transfer_ctrl (
        .clk       (clk),
        .rstN      (rstN),
        .valid     (valid),
        .last      (last),
        .ready     (ready),
        .frame     (frame_bus.controller),
        .word      (word_bus.controller),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_raddr (mem_raddr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    slave_memory u_slave_memory (
        .clk   (clk),
        .we    (mem_we),
        .waddr (mem_waddr),
        .raddr (mem_raddr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

/* tests/tb_bus_slave.sv */
`timescale 1ns/1ps
`include "slave_defs.svh"

module tb_bus_slave;

    localparam int dw             = `SLAVE_DATA_WIDTH;
    localparam int aw             = `SLAVE_ADDR_WIDTH;
    localparam int tb_slave_id    = 1;
    localparam int timeout_cycles = 200;

    logic clk;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic last;
    logic rD;
    logic ready;

    logic [31:0]   rng_state;
    logic [dw-1:0] model_mem [0:`SLAVE_MEM_DEPTH-1];

    bus_slave #(
        .slave_id (tb_slave_id)
    ) uut (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wD      (wD),
        .valid   (valid),
        .last    (last),
        .rD      (rD),
        .ready   (ready)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    function automatic bus_frame_pkg::frame_word_t make_frame(
        input logic [2:0]                 code,
        input logic [`SLAVE_ID_WIDTH-1:0] id,
        input bus_frame_pkg::xfer_dir_t   dir,
        input logic                       burst,
        input logic [aw-1:0]              addr
    );
        bus_frame_pkg::frame_word_t f;
        f.fields.start_code = code;
        f.fields.id         = id;
        f.fields.dir        = dir;
        f.fields.burst      = burst;
        f.fields.address    = addr;
        return f;
    endfunction

    task automatic abort_run();
        $display("Finished with errors");
        $fatal;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        slave_state_pkg::ctrl_state_t st;
        st = uut.u_transfer_ctrl.state;
        $display("Timed out waiting for %s, controller state is %s", what, st.name());
        abort_run();
    endtask

    // returns the number of cycles ready stayed low
    task automatic wait_ready(input string what, output int zeros);
        zeros = 0;
        while (ready !== 1'b1) begin
            @(negedge clk);
            zeros++;
            if (zeros > timeout_cycles) report_timeout(what);
        end
    endtask

    // master holds valid low for a few cycles
    task automatic random_pause();
        logic [31:0] r;
        next_rand(r);
        if (r[1:0] == 2'b00) begin
            valid = 1'b0;
            repeat (1 + r[3:2]) @(negedge clk);
        end
    endtask

    // ends one cycle after accept when the controller has left idle
    task automatic send_frame(input bus_frame_pkg::frame_word_t f, input logic expect_idle);
        int i;
        for (i = `SLAVE_FRAME_BITS - 1; i >= 0; i--) begin
            control = f.raw[i];
            if (expect_idle) check_value("ready", ready, 1);
            @(negedge clk);
        end
        control = 1'b0;
        if (expect_idle) check_value("ready", ready, 1);
        @(negedge clk);
    endtask

    task automatic write_word(input logic [dw-1:0] data, input logic end_burst);
        int   b;
        int   tries;
        logic taken;
        for (b = dw - 1; b >= 0; b--) begin
            random_pause();
            taken = 1'b0;
            tries = 0;
            // bit is taken on the edge where ready is high
            while (!taken) begin
                valid = 1'b1;
                wD    = data[b];
                last  = end_burst && (b == 0);
                taken = ready;
                @(negedge clk);
                valid = 1'b0;
                last  = 1'b0;
                tries++;
                if (tries > timeout_cycles) report_timeout("write bit");
            end
        end
    endtask

    task automatic finish_write();
        int zeros;
        int waited;
        waited = 0;
        while (ready === 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > timeout_cycles) report_timeout("write store");
        end
        wait_ready("end of write store", zeros);
        check_value("ready low cycles", zeros, 1);
    endtask

    task automatic write_transfer(input logic [aw-1:0] addr, input int n, input logic burst);
        int            w;
        logic [31:0]   r;
        logic [aw-1:0] a;
        send_frame(make_frame(`SLAVE_START_CODE, `SLAVE_ID_WIDTH'(tb_slave_id),
                              bus_frame_pkg::xfer_write, burst, addr), 1'b0);
        a = addr;
        for (w = 0; w < n; w++) begin
            next_rand(r);
            model_mem[a] = r;
            write_word(r, burst && (w == n - 1));
            a = a + 1'b1;
        end
        finish_write();
    endtask

    task automatic read_word(input logic [dw-1:0] exp, input logic end_burst,
                             input logic first);
        int b;
        int zeros;
        for (b = dw - 1; b >= 0; b--) begin
            wait_ready("read data", zeros);
            if (first && b == dw - 1) begin
                check_value("ready low cycles", zeros, `SLAVE_READ_DELAY + 1);
            end
            random_pause();
            check_value("rD", rD, exp[b]);
            valid = 1'b1;
            last  = end_burst && (b == 0);
            @(negedge clk);
            valid = 1'b0;
            last  = 1'b0;
        end
    endtask

    task automatic read_transfer(input logic [aw-1:0] addr, input int n, input logic burst);
        int            w;
        int            zeros;
        logic [aw-1:0] a;
        send_frame(make_frame(`SLAVE_START_CODE, `SLAVE_ID_WIDTH'(tb_slave_id),
                              bus_frame_pkg::xfer_read, burst, addr), 1'b0);
        a = addr;
        for (w = 0; w < n; w++) begin
            read_word(model_mem[a], burst && (w == n - 1), w == 0);
            a = a + 1'b1;
        end
        wait_ready("return to idle", zeros);
    endtask

    // frame for another slave or with a broken start code followed by a data phase
    task automatic send_foreign_write(input logic [aw-1:0] addr, input logic wrong_code);
        logic [31:0]                r;
        logic [2:0]                 code;
        logic [`SLAVE_ID_WIDTH-1:0] id;
        int                         b;
        next_rand(r);
        code = `SLAVE_START_CODE;
        id   = `SLAVE_ID_WIDTH'(tb_slave_id);
        if (wrong_code) begin
            code = 3'b100 + 3'(r[7:0] % 3);
        end else begin
            id = `SLAVE_ID_WIDTH'(tb_slave_id + 1 + r[7:0] % 3);
        end
        send_frame(make_frame(code, id, bus_frame_pkg::xfer_write, r[8], addr), 1'b1);
        for (b = 0; b < dw; b++) begin
            valid = 1'b1;
            wD    = r[b];
            check_value("ready", ready, 1);
            @(negedge clk);
        end
        valid = 1'b0;
        check_value("ready", ready, 1);
        // a write the slave took would be storing its word in this cycle
        @(negedge clk);
        check_value("ready", ready, 1);
    endtask

    initial begin
        logic [31:0]   r;
        logic [aw-1:0] addr;
        int            n;
        int            k;
        rng_state = 32'd85029;
        clk       = 1'b0;
        rstN      = 1'b0;
        control   = 1'b0;
        wD        = 1'b0;
        valid     = 1'b0;
        last      = 1'b0;
        repeat (8) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        check_value("ready", ready, 1);
        check_value("rD", rD, 0);

        // single words
        for (k = 0; k < 6; k++) begin
            next_rand(r);
            addr = r[aw-1:0];
            write_transfer(addr, 1, 1'b0);
            read_transfer(addr, 1, 1'b0);
        end

        // bursts of 2 to 6 words
        for (k = 0; k < 5; k++) begin
            next_rand(r);
            addr = r[aw-1:0];
            n    = 2 + r[15:8] % 5;
            write_transfer(addr, n, 1'b1);
            read_transfer(addr, n, 1'b1);
        end

        // frames this slave must drop
        for (k = 0; k < 4; k++) begin
            next_rand(r);
            addr = r[aw-1:0];
            write_transfer(addr, 1, 1'b0);
            send_foreign_write(addr, k[0]);
            read_transfer(addr, 1, 1'b0);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* compile.f */
+incdir+include
verilog/bus_frame_pkg.sv
verilog/slave_state_pkg.sv
verilog/slave_ifs.sv
verilog/frame_receiver.sv
verilog/word_shifter.sv
verilog/slave_memory.sv
verilog/transfer_ctrl.sv
verilog/bus_slave.sv
tests/tb_bus_slave.sv

/* Bender.yml */
package:
  name: bus_slave

export_include_dirs:
  - include

sources:
  - verilog/bus_frame_pkg.sv
  - verilog/slave_state_pkg.sv
  - verilog/slave_ifs.sv
  - verilog/frame_receiver.sv
  - verilog/word_shifter.sv
  - verilog/slave_memory.sv
  - verilog/transfer_ctrl.sv
  - verilog/bus_slave.sv
  - target: test
    files:
      - tests/tb_bus_slave.sv
